// ==== list.f ====
source/ps2_timing_pkg.sv
source/ps2_frame_pkg.sv
source/ps2_line_phy.sv
source/ps2_receiver.sv
source/ps2_transmitter.sv
source/ps2_line_arbiter.sv
source/ps2_controller.sv
verif/ps2_device_model.sv
verif/ps2_controller_tb.sv

// ==== source/ps2_controller.sv ====
/* Host-side PS/2 port controller top level
   Connects the line interface, the arbiter and the receive and transmit engines */
`default_nettype none

module ps2_controller (
	input wire clk,
	input wire reset,
	input wire ps2_frame_pkg::ps2_byte_t command,
	input wire send_command,
	inout wire ps2_clk,
	inout wire ps2_dat,
	output wire command_done,
	output wire command_error,
	output wire ps2_frame_pkg::ps2_byte_t received_data,
	output wire received_valid
);

	// Synchronized line view
	wire clk_rise;
	wire clk_fall;
	wire dat_sync;

	// Pull-down requests from the transmitter
	wire clk_low;
	wire dat_low;

	// Arbiter to and from the peers
	wire rx_enable;
	wire rx_busy;
	wire tx_start;
	wire tx_done;
	wire tx_timeout;

	ps2_line_phy u_phy (
		.clk      (clk),
		.reset    (reset),
		.clk_low  (clk_low),
		.dat_low  (dat_low),
		.ps2_clk  (ps2_clk),
		.ps2_dat  (ps2_dat),
		.clk_rise (clk_rise),
		.clk_fall (clk_fall),
		.dat_sync (dat_sync)
	);

	ps2_line_arbiter u_arbiter (
		.clk           (clk),
		.reset         (reset),
		.send_command  (send_command),
		.rx_busy       (rx_busy),
		.tx_done       (tx_done),
		.tx_timeout    (tx_timeout),
		.rx_enable     (rx_enable),
		.tx_start      (tx_start),
		.command_done  (command_done),
		.command_error (command_error)
	);

	ps2_receiver u_receiver (
		.clk            (clk),
		.reset          (reset),
		.rx_enable      (rx_enable),
		.clk_rise       (clk_rise),
		.dat_sync       (dat_sync),
		.rx_busy        (rx_busy),
		.received_data  (received_data),
		.received_valid (received_valid)
	);

	ps2_transmitter u_transmitter (
		.clk        (clk),
		.reset      (reset),
		.tx_start   (tx_start),
		.command    (command),
		.clk_rise   (clk_rise),
		.clk_fall   (clk_fall),
		.clk_low    (clk_low),
		.dat_low    (dat_low),
		.tx_done    (tx_done),
		.tx_timeout (tx_timeout)
	);

endmodule

`default_nettype wire

// ==== source/ps2_frame_pkg.sv ====
/* PS/2 frame layout, the data byte type and the FSM state encodings
   Shared by the receiver, transmitter, arbiter and top level */
`default_nettype none

package ps2_frame_pkg;

	// Payload bits per frame, sent LSB first
	localparam int DATA_BITS = 8;

	// One byte of payload
	typedef logic [DATA_BITS-1:0] ps2_byte_t;

	// Device-to-host frame tracking
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	// Host-to-device command sequence
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_INHIBIT,
		TX_WAIT_CLOCK,
		TX_DATA,
		TX_STOP,
		TX_ACK,
		TX_DONE,
		TX_ERROR
	} tx_state_t;

	// Bus ownership and command handshake
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_COMMAND,
		ARB_HOLD
	} arb_state_t;

endpackage

`default_nettype wire

// ==== source/ps2_line_arbiter.sv ====
/* Bus owner selection between receiver and transmitter
   Also runs the four-phase command handshake with the user */
`default_nettype none

module ps2_line_arbiter (
	input wire clk,
	input wire reset,
	input wire send_command,
	input wire rx_busy,
	input wire tx_done,
	input wire tx_timeout,
	output logic rx_enable,
	output logic tx_start,
	output logic command_done,
	output logic command_error
);

	import ps2_frame_pkg::*;
	import ps2_timing_pkg::*;

	arb_state_t state;
	arb_state_t state_next;

	// Quiet cycles seen since the bus went idle
	logic [SETTLE_WIDTH-1:0] settle_count;
	logic bus_settled;
	logic grant;

	assign bus_settled = (settle_count == SETTLE_WIDTH'(IDLE_SETTLE_CYCLES));

	// Request on a settled bus with no frame arriving
	assign grant = (state == ARB_IDLE) && send_command && bus_settled && !rx_busy;

	always_comb
	begin
		state_next = state;
		case (state)
			ARB_IDLE:
				if (grant)
					state_next = ARB_COMMAND;
			ARB_COMMAND:
				if (tx_done || tx_timeout)
					state_next = ARB_HOLD;
			ARB_HOLD:
				// Flag held until the user lets go
				if (!send_command)
					state_next = ARB_IDLE;
			default:
				state_next = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ARB_IDLE;
		else
			state <= state_next;
	end

	// Any receiver activity restarts the settle time
	always_ff @(posedge clk)
	begin
		if (reset)
			settle_count <= '0;
		else if (state != ARB_IDLE || rx_busy)
			settle_count <= '0;
		else if (!bus_settled)
			settle_count <= settle_count + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tx_start <= 1'b0;
			command_done <= 1'b0;
			command_error <= 1'b0;
		end
		else
		begin
			tx_start <= grant;
			if (state == ARB_COMMAND && tx_done)
				command_done <= 1'b1;
			else if (state == ARB_HOLD && !send_command)
				command_done <= 1'b0;
			if (state == ARB_COMMAND && tx_timeout)
				command_error <= 1'b1;
			else if (state == ARB_HOLD && !send_command)
				command_error <= 1'b0;
		end
	end

	// Receiver blind during the command and in the grant cycle
	// Left on in HOLD to catch the device's reply
	assign rx_enable = (state == ARB_HOLD) || ((state == ARB_IDLE) && !grant);

	// Receiver cannot pick up a start bit in the cycle the bus is handed over
	assert property (@(posedge clk) disable iff (reset)
		tx_start |-> !rx_busy);

endmodule

`default_nettype wire

// ==== source/ps2_line_phy.sv ====
/* Line interface for the two open-drain PS/2 wires
   Synchronizes both lines, flags device clock edges and pulls lines low on request */
`default_nettype none

module ps2_line_phy (
	input wire clk,
	input wire reset,
	input wire clk_low,
	input wire dat_low,
	inout wire ps2_clk,
	inout wire ps2_dat,
	output logic clk_rise,
	output logic clk_fall,
	output logic dat_sync
);

	// Two-stage synchronizers plus one history stage for the clock
	logic clk_meta;
	logic clk_sync;
	logic clk_prev;
	logic dat_meta;

	// Idle bus reads high through the pull-ups
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_meta <= 1'b1;
			clk_sync <= 1'b1;
			clk_prev <= 1'b1;
			dat_meta <= 1'b1;
			dat_sync <= 1'b1;
		end
		else
		begin
			clk_meta <= ps2_clk;
			clk_sync <= clk_meta;
			clk_prev <= clk_sync;
			dat_meta <= ps2_dat;
			dat_sync <= dat_meta;
		end
	end

	// Edge pulses from the last two clock samples
	assign clk_rise = clk_sync & ~clk_prev;
	assign clk_fall = ~clk_sync & clk_prev;

	// Open drain, only ever pull low or let go
	assign ps2_clk = clk_low ? 1'b0 : 1'bz;
	assign ps2_dat = dat_low ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

// ==== source/ps2_receiver.sv ====
/* Device-to-host frame receiver
   Finds the start bit, shifts in the byte LSB first and strobes it out at the stop bit */
`default_nettype none

module ps2_receiver (
	input wire clk,
	input wire reset,
	input wire rx_enable,
	input wire clk_rise,
	input wire dat_sync,
	output logic rx_busy,
	output ps2_frame_pkg::ps2_byte_t received_data,
	output logic received_valid
);

	import ps2_frame_pkg::*;

	rx_state_t state;
	rx_state_t state_next;

	// Data bit position inside the frame
	logic [$clog2(DATA_BITS)-1:0] bit_count;
	logic last_data_bit;

	// Bits arrive LSB first, so shift in from the top
	ps2_byte_t shift_reg;

	assign last_data_bit = (bit_count == ($clog2(DATA_BITS))'(DATA_BITS - 1));

	always_comb
	begin
		state_next = state;
		case (state)
			RX_IDLE:
				// Low data at a rising clock is a start bit
				if (rx_enable && clk_rise && !dat_sync)
					state_next = RX_DATA;
			RX_DATA:
				if (clk_rise && last_data_bit)
					state_next = RX_PARITY;
			RX_PARITY:
				// Parity sampled but not checked
				if (clk_rise)
					state_next = RX_STOP;
			RX_STOP:
				if (clk_rise)
					state_next = RX_IDLE;
			default:
				state_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= RX_IDLE;
		else
			state <= state_next;
	end

	// Counts only while shifting, cleared in every other state
	always_ff @(posedge clk)
	begin
		if (reset)
			bit_count <= '0;
		else if (state != RX_DATA)
			bit_count <= '0;
		else if (clk_rise)
			bit_count <= bit_count + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && clk_rise)
			shift_reg <= {dat_sync, shift_reg[DATA_BITS-1:1]};
	end

	// Byte held until the next frame ends
	always_ff @(posedge clk)
	begin
		if (state == RX_STOP && clk_rise)
			received_data <= shift_reg;
	end

	// One-cycle strobe after the stop bit clock
	always_ff @(posedge clk)
	begin
		if (reset)
			received_valid <= 1'b0;
		else
			received_valid <= (state == RX_STOP) && clk_rise;
	end

	// Busy from start bit through stop bit
	assign rx_busy = (state != RX_IDLE);

endmodule

`default_nettype wire

// ==== source/ps2_timing_pkg.sv ====
/* Protocol time limits for the PS/2 port, counted in 25 MHz system cycles
   Imported by the blocks that own interval counters */
`default_nettype none

package ps2_timing_pkg;

	// System clock feeding every counter
	localparam int SYS_CLK_HZ = 25_000_000;

	// Host holds the clock low this long before a command, 101 us
	localparam int INHIBIT_CYCLES = SYS_CLK_HZ / 1_000_000 * 101;

	// Device must start clocking within 15 ms of request-to-send
	localparam int CLOCK_WAIT_CYCLES = SYS_CLK_HZ / 1_000 * 15;

	// Data, stop and acknowledge must finish within 2 ms
	localparam int TRANSFER_CYCLES = SYS_CLK_HZ / 1_000 * 2;

	// Quiet bus needed before a command may start
	localparam int IDLE_SETTLE_CYCLES = 255;

	// Counter widths, sized to hold each limit
	localparam int INHIBIT_WIDTH = $clog2(INHIBIT_CYCLES);
	localparam int WAIT_WIDTH = $clog2(CLOCK_WAIT_CYCLES);
	localparam int TRANSFER_WIDTH = $clog2(TRANSFER_CYCLES);
	localparam int SETTLE_WIDTH = $clog2(IDLE_SETTLE_CYCLES + 1);

endpackage

`default_nettype wire

// ==== source/ps2_transmitter.sv ====
/* Host-to-device command sender with request-to-send, bit shifting and acknowledge
   Started by a one-cycle pulse, ends with a done or timeout pulse */
`default_nettype none

module ps2_transmitter (
	input wire clk,
	input wire reset,
	input wire tx_start,
	input wire ps2_frame_pkg::ps2_byte_t command,
	input wire clk_rise,
	input wire clk_fall,
	output logic clk_low,
	output logic dat_low,
	output logic tx_done,
	output logic tx_timeout
);

	import ps2_frame_pkg::*;
	import ps2_timing_pkg::*;

	tx_state_t state;
	tx_state_t state_next;

	// Parity on top of the byte, bit 0 is always on the line
	logic [DATA_BITS:0] frame_bits;
	logic [$clog2(DATA_BITS + 1)-1:0] bit_index;

	// Interval counters
	logic [INHIBIT_WIDTH-1:0] inhibit_count;
	logic [WAIT_WIDTH-1:0] wait_count;
	logic [TRANSFER_WIDTH-1:0] transfer_count;

	logic inhibit_over;
	logic wait_expired;
	logic transfer_expired;
	logic in_transfer;
	logic last_bit;

	assign inhibit_over = (inhibit_count == INHIBIT_WIDTH'(INHIBIT_CYCLES - 1));
	assign wait_expired = (wait_count == WAIT_WIDTH'(CLOCK_WAIT_CYCLES - 1));
	assign transfer_expired = (transfer_count == TRANSFER_WIDTH'(TRANSFER_CYCLES - 1));
	assign in_transfer = (state == TX_DATA) || (state == TX_STOP) || (state == TX_ACK);
	assign last_bit = (bit_index == ($clog2(DATA_BITS + 1))'(DATA_BITS));

	always_comb
	begin
		state_next = state;
		case (state)
			TX_IDLE:
				if (tx_start)
					state_next = TX_INHIBIT;
			TX_INHIBIT:
				if (inhibit_over)
					state_next = TX_WAIT_CLOCK;
			TX_WAIT_CLOCK:
				// First device falling edge takes bit 0
				if (clk_fall)
					state_next = TX_DATA;
				else if (wait_expired)
					state_next = TX_ERROR;
			TX_DATA:
				// Tenth fall ends parity, line goes to the stop bit
				if (clk_fall && last_bit)
					state_next = TX_STOP;
				else if (transfer_expired)
					state_next = TX_ERROR;
			TX_STOP:
				if (clk_fall)
					state_next = TX_ACK;
				else if (transfer_expired)
					state_next = TX_ERROR;
			TX_ACK:
				// Device releases clock after pulling data low
				if (clk_rise)
					state_next = TX_DONE;
				else if (transfer_expired)
					state_next = TX_ERROR;
			default:
				// Done and error last a single cycle
				state_next = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= TX_IDLE;
		else
			state <= state_next;
	end

	// Odd parity, ones in all nine bits add up odd
	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && tx_start)
			frame_bits <= {~^command, command};
		else if (state == TX_DATA && clk_fall)
			frame_bits <= {1'b1, frame_bits[DATA_BITS:1]};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			bit_index <= '0;
		else if (state != TX_DATA)
			bit_index <= '0;
		else if (clk_fall)
			bit_index <= bit_index + 1'b1;
	end

	// Request-to-send length
	always_ff @(posedge clk)
	begin
		if (reset)
			inhibit_count <= '0;
		else if (state == TX_INHIBIT)
			inhibit_count <= inhibit_count + 1'b1;
		else
			inhibit_count <= '0;
	end

	// 15 ms for the device to begin clocking
	always_ff @(posedge clk)
	begin
		if (reset)
			wait_count <= '0;
		else if (state == TX_WAIT_CLOCK)
			wait_count <= wait_count + 1'b1;
		else
			wait_count <= '0;
	end

	// One 2 ms window across data, stop and acknowledge
	always_ff @(posedge clk)
	begin
		if (reset)
			transfer_count <= '0;
		else if (in_transfer)
			transfer_count <= transfer_count + 1'b1;
		else
			transfer_count <= '0;
	end

	assign clk_low = (state == TX_INHIBIT);

	always_comb
	begin
		case (state)
			TX_INHIBIT:
				// Start bit goes out in the second half of the inhibit
				dat_low = (inhibit_count >= INHIBIT_WIDTH'(INHIBIT_CYCLES / 2));
			TX_WAIT_CLOCK:
				dat_low = 1'b1;
			TX_DATA:
				dat_low = ~frame_bits[0];
			default:
				dat_low = 1'b0;
		endcase
	end

	assign tx_done = (state == TX_DONE);
	assign tx_timeout = (state == TX_ERROR);

	// Arbiter never restarts a command that is still running
	assert property (@(posedge clk) disable iff (reset)
		tx_start |-> (state == TX_IDLE));

endmodule

`default_nettype wire

// ==== verif/ps2_controller_tb.sv ====
/* Testbench for the PS/2 port controller
   Covers reset state, device frames, commands, device timeout and a command reply */
`default_nettype none

module ps2_controller_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import ps2_frame_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int FRAME_COUNT = 20;
	// Timeout test of 375k cycles plus about 30 frames, with margin
	localparam int CYCLE_LIMIT = 1_000_000;
	localparam int FRAME_WAIT = 200;
	localparam int REPLY_WAIT = 1_000;
	localparam int COMMAND_WAIT = 5_000;
	localparam int SILENT_WAIT = 400_000;
	localparam int SETTLE_GAP = 300;

	logic clk;
	logic reset;
	ps2_byte_t command;
	logic send_command;
	wire ps2_clk;
	wire ps2_dat;
	wire command_done;
	wire command_error;
	wire [DATA_BITS-1:0] received_data;
	wire received_valid;

	integer seed;
	int errors = 0;
	int rx_count = 0;
	int cycle_count = 0;
	ps2_byte_t expected_byte;
	// Bytes the device has sent, oldest first
	ps2_byte_t expected_bytes[$];

	// Bus pull-ups
	pullup (ps2_clk);
	pullup (ps2_dat);

	ps2_controller u_dut (
		.clk            (clk),
		.reset          (reset),
		.command        (command),
		.send_command   (send_command),
		.ps2_clk        (ps2_clk),
		.ps2_dat        (ps2_dat),
		.command_done   (command_done),
		.command_error  (command_error),
		.received_data  (received_data),
		.received_valid (received_valid)
	);

	ps2_device_model u_device (
		.clk     (clk),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: simulation passed %0d cycles without finishing", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// Odd parity, counted bit by bit
	function automatic logic expected_parity(input ps2_byte_t value);
		int ones;
		ones = 0;
		for (int i = 0; i < DATA_BITS; i++)
			ones += value[i];
		return (ones % 2 == 0);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
		errors++;
	endtask

	// Every strobe must match the oldest byte sent
	always @(negedge clk)
	begin
		if (!reset && received_valid === 1'b1)
		begin
			rx_count++;
			if (expected_bytes.size() == 0)
			begin
				$display("Byte %0h reported at %0t ns with none sent", received_data, $time);
				errors++;
			end
			else
			begin
				expected_byte = expected_bytes.pop_front();
				if (received_data !== expected_byte)
					report_mismatch("received_data", expected_byte, received_data);
			end
		end
	end

	task automatic wait_for_reports(input int limit);
		int waited;
		waited = 0;
		while (expected_bytes.size() != 0 && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (expected_bytes.size() != 0)
		begin
			$display("Byte %0h sent by the device was never reported", expected_bytes[0]);
			errors++;
			expected_bytes.delete();
		end
	endtask

	task automatic wait_for_flag(input int limit);
		int waited;
		waited = 0;
		while (command_done !== 1'b1 && command_error !== 1'b1 && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (command_done !== 1'b1 && command_error !== 1'b1)
		begin
			$display("No command flag rose within %0d cycles", limit);
			errors++;
		end
	endtask

	// Request on a settled bus pulls the clock low within 2 cycles
	task automatic start_command(input ps2_byte_t value);
		@(negedge clk);
		command = value;
		send_command = 1'b1;
		repeat (2) @(negedge clk);
		if (ps2_clk !== 1'b0)
			report_mismatch("ps2_clk", 1'b0, ps2_clk);
	endtask

	task automatic check_flags_held(input int cycles, input logic done, input logic error);
		repeat (cycles)
		begin
			@(negedge clk);
			if (command_done !== done)
				report_mismatch("command_done", done, command_done);
			if (command_error !== error)
				report_mismatch("command_error", error, command_error);
		end
	endtask

	task automatic release_command();
		@(negedge clk);
		send_command = 1'b0;
		repeat (2) @(negedge clk);
		if (command_done !== 1'b0)
			report_mismatch("command_done", 1'b0, command_done);
		if (command_error !== 1'b0)
			report_mismatch("command_error", 1'b0, command_error);
	endtask

	initial
	begin
		ps2_byte_t value;
		int start_count;
		seed = 32'hbd27;
		reset = 1'b1;
		command = '0;
		send_command = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		// Idle bus, no strobes or flags
		if (ps2_clk !== 1'b1)
			report_mismatch("ps2_clk", 1'b1, ps2_clk);
		if (ps2_dat !== 1'b1)
			report_mismatch("ps2_dat", 1'b1, ps2_dat);
		if (received_valid !== 1'b0)
			report_mismatch("received_valid", 1'b0, received_valid);
		if (command_done !== 1'b0)
			report_mismatch("command_done", 1'b0, command_done);
		if (command_error !== 1'b0)
			report_mismatch("command_error", 1'b0, command_error);

		// Random device frames
		for (int i = 0; i < FRAME_COUNT; i++)
		begin
			value = ps2_byte_t'($random(seed));
			expected_bytes.push_back(value);
			u_device.send_frame(value);
			wait_for_reports(FRAME_WAIT);
		end
		if (rx_count != FRAME_COUNT)
			report_mismatch("received_valid count", FRAME_COUNT, rx_count);

		// Host command with acknowledge
		repeat (SETTLE_GAP) @(negedge clk);
		value = ps2_byte_t'($random(seed));
		start_count = u_device.command_count;
		start_command(value);
		wait_for_flag(COMMAND_WAIT);
		check_flags_held(10, 1'b1, 1'b0);
		if (u_device.command_count != start_count + 1)
		begin
			$display("Device did not capture the command byte");
			errors++;
		end
		if (u_device.captured_data !== value)
			report_mismatch("captured_data", value, u_device.captured_data);
		if (u_device.captured_parity !== expected_parity(value))
			report_mismatch("captured_parity", expected_parity(value), u_device.captured_parity);
		if (u_device.captured_stop !== 1'b1)
			report_mismatch("captured_stop", 1'b1, u_device.captured_stop);
		release_command();

		// Silent device, 15 ms wait expires
		repeat (SETTLE_GAP) @(negedge clk);
		u_device.silent = 1'b1;
		start_command(ps2_byte_t'($random(seed)));
		wait_for_flag(SILENT_WAIT);
		check_flags_held(10, 1'b0, 1'b1);
		release_command();
		u_device.silent = 1'b0;

		// Reply byte right after the acknowledge, request still held
		repeat (SETTLE_GAP) @(negedge clk);
		u_device.reply_enable = 1'b1;
		start_count = rx_count;
		expected_bytes.push_back(8'hfa);
		start_command(ps2_byte_t'($random(seed)));
		wait_for_flag(COMMAND_WAIT);
		wait_for_reports(REPLY_WAIT);
		check_flags_held(1, 1'b1, 1'b0);
		release_command();
		u_device.reply_enable = 1'b0;
		repeat (100) @(negedge clk);
		if (rx_count != start_count + 1)
			report_mismatch("received_valid count", start_count + 1, rx_count);

		$display("Run complete: %0d errors, %0d bytes received", errors, rx_count);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/ps2_device_model.sv ====
/* Behavioral PS/2 device for the controller testbench
   Sends frames on request, captures host commands, acknowledges or stays silent */
`default_nettype none

module ps2_device_model (
	input wire clk,
	inout wire ps2_clk,
	inout wire ps2_dat
);

	timeunit 1ns;
	timeprecision 100ps;

	// Device clock half period in system cycles
	localparam int HALF_PERIOD = 25;

	// Acknowledge byte sent back after a command
	localparam logic [7:0] REPLY_BYTE = 8'hfa;

	// Open-drain pulls
	logic clk_pull = 1'b0;
	logic dat_pull = 1'b0;

	// Own clock activity, keeps the command watcher quiet
	logic sending = 1'b0;

	// Controls set by the testbench
	logic silent = 1'b0;
	logic reply_enable = 1'b0;

	// Last command seen on the bus
	logic [7:0] captured_data = 8'h00;
	logic captured_parity = 1'b0;
	logic captured_stop = 1'b0;
	int command_count = 0;

	assign ps2_clk = clk_pull ? 1'b0 : 1'bz;
	assign ps2_dat = dat_pull ? 1'b0 : 1'bz;

	task automatic wait_cycles(input int count);
		repeat (count) @(negedge clk);
	endtask

	// Start, data LSB first, odd parity, stop
	task automatic send_frame(input logic [7:0] value);
		logic [10:0] bits;
		bits = {1'b1, ~^value, value, 1'b0};
		sending = 1'b1;
		for (int i = 0; i < 11; i++)
		begin
			clk_pull = 1'b1;
			// Data changes mid-way through the low phase
			wait_cycles(HALF_PERIOD / 2);
			dat_pull = ~bits[i];
			wait_cycles(HALF_PERIOD - HALF_PERIOD / 2);
			// Host samples at this rising edge
			clk_pull = 1'b0;
			wait_cycles(HALF_PERIOD);
		end
		sending = 1'b0;
	endtask

	// Ten clocks for data, parity and stop, then the acknowledge clock
	task automatic receive_command();
		logic [9:0] bits;
		wait_cycles(HALF_PERIOD);
		for (int i = 0; i < 10; i++)
		begin
			clk_pull = 1'b1;
			wait_cycles(HALF_PERIOD);
			clk_pull = 1'b0;
			// Host bit read at the rising edge
			bits[i] = (ps2_dat !== 1'b0);
			wait_cycles(HALF_PERIOD);
		end
		// Data held low across the last clock pulse
		dat_pull = 1'b1;
		clk_pull = 1'b1;
		wait_cycles(HALF_PERIOD);
		clk_pull = 1'b0;
		wait_cycles(5);
		dat_pull = 1'b0;
		captured_data = bits[7:0];
		captured_parity = bits[8];
		captured_stop = bits[9];
		command_count++;
	endtask

	// Inhibit then released clock with data low is a request-to-send
	initial
	begin
		forever
		begin
			wait (ps2_clk === 1'b0 && !sending);
			wait (ps2_clk === 1'b1);
			if (ps2_dat === 1'b0)
			begin
				if (silent)
					// Host gives up and lets the data line go
					wait (ps2_dat === 1'b1);
				else
				begin
					receive_command();
					if (reply_enable)
					begin
						wait_cycles(HALF_PERIOD);
						send_frame(REPLY_BYTE);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire
